//--- sim.f
source/heap_pkg.sv
source/alloc_dispatcher.sv
source/heap_bank.sv
source/gc_merger.sv
source/heap_top.sv
bench/heap_tb.sv

//--- Bender.yml
package:
  name: gc_heap

sources:
  - source/heap_pkg.sv
  - source/alloc_dispatcher.sv
  - source/heap_bank.sv
  - source/gc_merger.sv
  - source/heap_top.sv
  - target: test
    files:
      - bench/heap_tb.sv

//--- bench/heap_tb.sv
`timescale 1ns/100ps

module heap_tb;

	logic gc;
	logic reset;
	logic alloc_valid;
	logic [heap_pkg::size_width-1:0] alloc_size;
	logic alloc_refers;
	heap_pkg::heap_payload_u alloc_payload;
	logic unroot_valid;
	logic [heap_pkg::bank_index_width-1:0] unroot_bank;
	logic [heap_pkg::slot_index_width-1:0] unroot_slot;
	logic rd_valid;
	logic [heap_pkg::bank_index_width-1:0] rd_bank;
	logic [heap_pkg::slot_index_width-1:0] rd_slot;
	logic gc_request;
	logic alloc_done;
	logic alloc_ok;
	logic [heap_pkg::bank_index_width-1:0] alloc_bank;
	logic [heap_pkg::slot_index_width-1:0] alloc_slot;
	logic rd_done;
	logic [heap_pkg::heap_width-1:0] rd_data;
	logic gc_busy;
	logic gc_done;
	logic [heap_pkg::freed_width-1:0] freed_total;

	// reference model of the heap, one entry per slot
	bit model_used [heap_pkg::num_banks][heap_pkg::slots_per_bank];
	bit model_head [heap_pkg::num_banks][heap_pkg::slots_per_bank];
	bit model_root [heap_pkg::num_banks][heap_pkg::slots_per_bank];
	bit model_refers [heap_pkg::num_banks][heap_pkg::slots_per_bank];
	logic [heap_pkg::size_width-1:0] model_size [heap_pkg::num_banks][heap_pkg::slots_per_bank];
	logic [15:0] model_payload [heap_pkg::num_banks][heap_pkg::slots_per_bank];
	int model_live;
	int seed;
	int errors;
	int failures;
	int last_bank;
	int last_slot;
	bit last_ok;

	// expected responses, set when the matching command is driven
	logic exp_ok;
	logic [heap_pkg::bank_index_width-1:0] exp_bank;
	logic [heap_pkg::slot_index_width-1:0] exp_slot;
	logic [heap_pkg::heap_width-1:0] exp_word;
	logic [heap_pkg::heap_width-1:0] exp_mask;
	logic [heap_pkg::freed_width-1:0] exp_freed;
	logic auto_due;           // this allocation takes the live count up to the threshold

	heap_top heap_top_inst (.*);

	always #4 gc = ~gc;

	task automatic report_value(input string what);
		errors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	assert property (@(posedge gc) reset |=> !alloc_done && !rd_done && !gc_busy && !gc_done)
		else report_value("response strobes or gc_busy not low after reset");
	assert property (@(posedge gc) disable iff (reset) alloc_valid |=> alloc_done)
		else report_value("alloc_done missing one cycle after alloc_valid");
	assert property (@(posedge gc) disable iff (reset) alloc_done |->
		alloc_ok == exp_ok && (!exp_ok || (alloc_bank == exp_bank && alloc_slot == exp_slot)))
		else report_value($sformatf("alloc result %0b at %0d/%0d, model %0b at %0d/%0d",
			alloc_ok, alloc_bank, alloc_slot, exp_ok, exp_bank, exp_slot));
	assert property (@(posedge gc) disable iff (reset) alloc_valid && gc_busy |=> !alloc_ok)
		else report_value("allocation accepted during collection");
	assert property (@(posedge gc) disable iff (reset) rd_valid |=> rd_done)
		else report_value("rd_done missing one cycle after rd_valid");
	assert property (@(posedge gc) disable iff (reset)
		rd_done |-> ((rd_data ^ exp_word) & exp_mask) == '0)
		else report_value($sformatf("read word %h, model %h", rd_data, exp_word));
	assert property (@(posedge gc) disable iff (reset) gc_done |-> freed_total == exp_freed && !gc_busy)
		else report_value($sformatf("freed_total %0d, model %0d", freed_total, exp_freed));
	assert property (@(posedge gc) disable iff (reset) gc_request && !gc_busy |=> gc_busy)
		else report_value("gc_busy did not rise one cycle after gc_request");
	// the live count lands with the write, gc_busy follows one cycle after that
	assert property (@(posedge gc) disable iff (reset)
		alloc_valid && auto_due |=> !gc_busy ##1 gc_busy)
		else report_value("automatic collection did not start one cycle after the threshold");

	// lowest bank first, then lowest slot, never running past the end of a bank
	function automatic bit find_fit(input int size, output int fb, output int fs);
		bit free_run;
		fb = 0;
		fs = 0;
		for (int b = 0; b < heap_pkg::num_banks; b++)
		begin
			for (int s = 0; s + size <= heap_pkg::slots_per_bank; s++)
			begin
				free_run = 1;
				for (int k = 0; k < size; k++)
					free_run = free_run && !model_used[b][s + k];
				if (free_run)
				begin
					fb = b;
					fs = s;
					return 1;
				end
			end
		end
		return 0;
	endfunction

	function automatic logic [heap_pkg::heap_width-1:0] model_word(input int b, input int s);
		logic [heap_pkg::heap_width-1:0] w;
		w = '0;
		w[heap_pkg::used_bit] = model_used[b][s];
		w[heap_pkg::head_bit] = model_head[b][s];
		w[heap_pkg::size_lsb +: heap_pkg::size_width] = model_size[b][s];
		w[heap_pkg::colour_lsb +: heap_pkg::colour_width] = heap_pkg::colour_white;
		w[heap_pkg::refers_bit] = model_refers[b][s];
		w[heap_pkg::payload_lsb +: heap_pkg::payload_width] = model_payload[b][s];
		return w;
	endfunction

	// marks from the roots along the links, then counts or frees whatever stayed unmarked
	task automatic collect_model(input bit apply, output int freed);
		bit reach [heap_pkg::slots_per_bank];
		bit grown [heap_pkg::slots_per_bank];
		bit owner_live;
		int target;
		freed = 0;
		for (int b = 0; b < heap_pkg::num_banks; b++)
		begin
			for (int s = 0; s < heap_pkg::slots_per_bank; s++)
				reach[s] = model_head[b][s] && model_root[b][s];
			repeat (heap_pkg::depth_of_graph)
			begin
				grown = reach;
				for (int s = 0; s < heap_pkg::slots_per_bank; s++)
				begin
					target = model_payload[b][s][heap_pkg::slot_index_width-1:0];
					if (reach[s] && model_refers[b][s] && model_head[b][target])
						grown[target] = 1;
				end
				reach = grown;
			end
			owner_live = 0;
			for (int s = 0; s < heap_pkg::slots_per_bank; s++)
			begin
				if (model_head[b][s])
					owner_live = reach[s];    // tails follow the head in front of them
				if (model_used[b][s] && !owner_live)
				begin
					freed++;
					if (apply)
					begin
						model_used[b][s] = 0;
						model_head[b][s] = 0;
					end
				end
			end
		end
		if (apply)
			model_live -= freed;
	endtask

	task automatic wait_collection();
		int cycles;
		cycles = 0;
		while (!gc_done && cycles < 40)
		begin
			@(posedge gc);
			#1;
			cycles++;
		end
		if (!gc_done)
		begin
			failures++;
			$display("collection never finished, no gc_done within %0d cycles", cycles);
		end
	endtask

	task automatic allocate(input int size, input bit refers, input logic [15:0] data,
		input bit busy);
		int fb;
		int fs;
		int freed;
		bit found;
		bit due;
		found = find_fit(size, fb, fs);
		exp_ok = found && !busy;
		exp_bank = fb[heap_pkg::bank_index_width-1:0];
		exp_slot = fs[heap_pkg::slot_index_width-1:0];
		due = exp_ok && model_live < heap_pkg::gc_threshold;
		due = due && model_live + size >= heap_pkg::gc_threshold;
		if (exp_ok)
		begin
			for (int k = 0; k < size; k++)
			begin
				model_used[fb][fs + k] = 1;
				model_head[fb][fs + k] = (k == 0);
				model_root[fb][fs + k] = (k == 0);
				model_refers[fb][fs + k] = refers && k == 0;
				model_size[fb][fs + k] = size[heap_pkg::size_width-1:0];
				model_payload[fb][fs + k] = (k == 0) ? data : '0;
			end
			model_live += size;
		end
		if (due)
		begin
			collect_model(0, freed);
			exp_freed = freed[heap_pkg::freed_width-1:0];
		end
		auto_due = due;
		alloc_valid = 1;
		alloc_size = size[heap_pkg::size_width-1:0];
		alloc_refers = refers;
		alloc_payload.data_word = data;
		@(posedge gc);
		#1;
		alloc_valid = 0;
		@(posedge gc);
		#1;
		auto_due = 0;
		last_ok = exp_ok;
		last_bank = fb;
		last_slot = fs;
		if (due)
		begin
			wait_collection();
			collect_model(1, freed);
		end
	endtask

	task automatic unroot(input int b, input int s);
		unroot_valid = 1;
		unroot_bank = b[heap_pkg::bank_index_width-1:0];
		unroot_slot = s[heap_pkg::slot_index_width-1:0];
		model_root[b][s] = 0;
		@(posedge gc);
		#1;
		unroot_valid = 0;
	endtask

	task automatic read_slot(input int b, input int s);
		exp_word = model_word(b, s);
		exp_mask = '1;
		if (!model_used[b][s])
		begin
			exp_mask = '0;
			exp_mask[heap_pkg::used_bit] = 1'b1;    // a free slot keeps a stale payload
		end
		rd_valid = 1;
		rd_bank = b[heap_pkg::bank_index_width-1:0];
		rd_slot = s[heap_pkg::slot_index_width-1:0];
		@(posedge gc);
		#1;
		rd_valid = 0;
		@(posedge gc);
		#1;
	endtask

	task automatic read_all();
		for (int b = 0; b < heap_pkg::num_banks; b++)
		begin
			for (int s = 0; s < heap_pkg::slots_per_bank; s++)
				read_slot(b, s);
		end
	endtask

	initial
	begin
		int size;
		int data;
		int freed;
		int fb;
		int fs;
		int garbage_bank;
		int garbage_slot;
		gc = 0;
		reset = 1;
		alloc_valid = 0;
		alloc_size = '0;
		alloc_refers = 0;
		alloc_payload = '0;
		unroot_valid = 0;
		unroot_bank = '0;
		unroot_slot = '0;
		rd_valid = 0;
		rd_bank = '0;
		rd_slot = '0;
		gc_request = 0;
		auto_due = 0;
		exp_freed = '0;
		model_live = 0;
		errors = 0;
		failures = 0;
		seed = 32'hb6e5;
		repeat (10) @(posedge gc);
		#1;
		reset = 0;

		// plain data blocks of random size, read back slot by slot
		for (int i = 0; i < 3; i++)
		begin
			size = ($random(seed) & 3) + 1;
			allocate(size, 0, 16'($random(seed)), 0);
			if (i == 0)
			begin
				garbage_bank = last_bank;
				garbage_slot = last_slot;
			end
			for (int k = 0; k < size; k++)
				read_slot(last_bank, last_slot + k);
		end

		// two chains of three, only the newest object of the first chain stays rooted
		for (int c = 0; c < 2; c++)
		begin
			for (int i = 0; i < 3; i++)
			begin
				data = $random(seed);
				data[2:0] = last_slot[2:0];    // link to the object allocated just before
				allocate(1, i > 0, data[15:0], 0);
				read_slot(last_bank, last_slot);
				if (i < 2 || c == 1)
					unroot(last_bank, last_slot);
			end
		end
		unroot(garbage_bank, garbage_slot);

		collect_model(0, freed);
		exp_freed = freed[heap_pkg::freed_width-1:0];
		gc_request = 1;
		@(posedge gc);
		#1;
		gc_request = 0;
		allocate(1, 0, 16'($random(seed)), 1);    // lands while the banks are collecting
		wait_collection();
		collect_model(1, freed);
		read_all();

		// new blocks should fill the lowest holes left by the sweep
		for (int i = 0; i < 2; i++)
		begin
			size = ($random(seed) & 3) + 1;
			allocate(size, 0, 16'($random(seed)), 0);
			for (int k = 0; k < size && last_ok; k++)
				read_slot(last_bank, last_slot + k);
		end

		while (model_live < heap_pkg::gc_threshold)
			allocate(1, 0, 16'($random(seed)), 0);
		while (find_fit(1, fb, fs))
			allocate(1, 0, 16'($random(seed)), 0);
		allocate(1, 0, 16'($random(seed)), 0);    // heap is full now
		read_all();

		$display("closing counts: %0d wrong values, %0d other failures", errors, failures);
		if (errors == 0 && failures == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// about 200 operations, each bounded by one worst case collection of 14 cycles
	initial
	begin
		repeat (200 * 14 + 100) @(posedge gc);
		$display("watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- source/heap_top.sv
`timescale 1ns/100ps

module heap_top
(
	input  logic gc,
	input  logic reset,
	input  logic alloc_valid,
	input  logic [heap_pkg::size_width-1:0] alloc_size,
	input  logic alloc_refers,
	input  heap_pkg::heap_payload_u alloc_payload,
	input  logic unroot_valid,
	input  logic [heap_pkg::bank_index_width-1:0] unroot_bank,
	input  logic [heap_pkg::slot_index_width-1:0] unroot_slot,
	input  logic rd_valid,
	input  logic [heap_pkg::bank_index_width-1:0] rd_bank,
	input  logic [heap_pkg::slot_index_width-1:0] rd_slot,
	input  logic gc_request,
	output logic alloc_done,
	output logic alloc_ok,
	output logic [heap_pkg::bank_index_width-1:0] alloc_bank,
	output logic [heap_pkg::slot_index_width-1:0] alloc_slot,
	output logic rd_done,
	output logic [heap_pkg::heap_width-1:0] rd_data,
	output logic gc_busy,
	output logic gc_done,
	output logic [heap_pkg::freed_width-1:0] freed_total
);

	logic [heap_pkg::num_banks-1:0] bank_wr;
	logic [heap_pkg::num_banks-1:0] bank_unroot;
	logic [heap_pkg::num_banks-1:0][heap_pkg::slots_per_bank-1:0] used_map;
	logic [heap_pkg::num_banks-1:0] bank_done;
	logic [heap_pkg::num_banks-1:0][heap_pkg::freed_width-1:0] bank_freed;
	logic [heap_pkg::num_banks-1:0][heap_pkg::heap_width-1:0] bank_rd_word;
	logic [heap_pkg::slot_index_width-1:0] wr_slot;
	logic [heap_pkg::size_width-1:0] wr_size;
	logic wr_refers;
	heap_pkg::heap_payload_u wr_payload;
	logic [heap_pkg::slot_index_width-1:0] bank_unroot_slot;
	logic gc_start;

	alloc_dispatcher alloc_dispatcher_inst
	(
		.gc(gc), .reset(reset),
		.alloc_valid(alloc_valid), .alloc_refers(alloc_refers),
		.alloc_size(alloc_size), .alloc_payload(alloc_payload),
		.unroot_valid(unroot_valid), .unroot_bank(unroot_bank), .unroot_slot(unroot_slot),
		.gc_request(gc_request), .used_map(used_map),
		.gc_done(gc_done), .freed_total(freed_total),
		.alloc_done(alloc_done), .alloc_ok(alloc_ok),
		.alloc_bank(alloc_bank), .alloc_slot(alloc_slot),
		.bank_wr(bank_wr), .wr_slot(wr_slot), .wr_size(wr_size),
		.wr_refers(wr_refers), .wr_payload(wr_payload),
		.bank_unroot(bank_unroot), .unroot_slot_out(bank_unroot_slot),
		.gc_start(gc_start), .gc_busy(gc_busy)
	);

	// one collector per bank, links never leave their bank
	for (genvar b = 0; b < heap_pkg::num_banks; b++)
	begin : gen_bank
		heap_bank heap_bank_inst
		(
			.gc(gc), .reset(reset),
			.wr_en(bank_wr[b]), .wr_slot(wr_slot), .wr_size(wr_size),
			.wr_refers(wr_refers), .wr_payload(wr_payload),
			.unroot_en(bank_unroot[b]), .unroot_slot(bank_unroot_slot),
			.gc_start(gc_start), .rd_slot(rd_slot),
			.used_map(used_map[b]), .rd_word(bank_rd_word[b]),
			.bank_done(bank_done[b]), .bank_freed(bank_freed[b])
		);
	end

	gc_merger gc_merger_inst
	(
		.gc(gc), .reset(reset),
		.bank_done(bank_done), .bank_freed(bank_freed),
		.rd_valid(rd_valid), .rd_bank(rd_bank), .bank_rd_word(bank_rd_word),
		.gc_done(gc_done), .freed_total(freed_total),
		.rd_done(rd_done), .rd_data(rd_data)
	);

endmodule

//--- source/gc_merger.sv
`timescale 1ns/100ps

module gc_merger
(
	input  logic gc,
	input  logic reset,
	input  logic [heap_pkg::num_banks-1:0] bank_done,
	input  logic [heap_pkg::num_banks-1:0][heap_pkg::freed_width-1:0] bank_freed,
	input  logic rd_valid,
	input  logic [heap_pkg::bank_index_width-1:0] rd_bank,
	input  logic [heap_pkg::num_banks-1:0][heap_pkg::heap_width-1:0] bank_rd_word,
	output logic gc_done,
	output logic [heap_pkg::freed_width-1:0] freed_total,
	output logic rd_done,
	output logic [heap_pkg::heap_width-1:0] rd_data
);

	logic [heap_pkg::num_banks-1:0] done_seen;
	logic [heap_pkg::num_banks-1:0] seen_next;
	logic [heap_pkg::freed_width-1:0] freed_acc;
	logic [heap_pkg::freed_width-1:0] sum_next;
	logic [heap_pkg::bank_index_width-1:0] rd_bank_q;

	// banks finish at different times since marking stops early per bank
	always_comb
	begin
		seen_next = done_seen | bank_done;
		sum_next = freed_acc;
		for (int b = 0; b < heap_pkg::num_banks; b++)
		begin
			if (bank_done[b])
				sum_next = sum_next + bank_freed[b];
		end
	end

	always_ff @(posedge gc)
	begin
		if (reset)
		begin
			done_seen <= '0;
			freed_acc <= '0;
			gc_done <= 1'b0;
			rd_done <= 1'b0;
		end
		else
		begin
			gc_done <= &seen_next;
			rd_done <= rd_valid;
			done_seen <= (&seen_next) ? '0 : seen_next;
			freed_acc <= (&seen_next) ? '0 : sum_next;
		end
	end

	always_ff @(posedge gc)
	begin
		if (&seen_next)
			freed_total <= sum_next;
		rd_bank_q <= rd_bank;
	end

	assign rd_data = bank_rd_word[rd_bank_q];    // bank words are already registered

endmodule

//--- source/heap_bank.sv
`timescale 1ns/100ps

module heap_bank
(
	input  logic gc,
	input  logic reset,
	input  logic wr_en,
	input  logic [heap_pkg::slot_index_width-1:0] wr_slot,
	input  logic [heap_pkg::size_width-1:0] wr_size,
	input  logic wr_refers,
	input  heap_pkg::heap_payload_u wr_payload,
	input  logic unroot_en,
	input  logic [heap_pkg::slot_index_width-1:0] unroot_slot,
	input  logic gc_start,
	input  logic [heap_pkg::slot_index_width-1:0] rd_slot,
	output logic [heap_pkg::slots_per_bank-1:0] used_map,
	output logic [heap_pkg::heap_width-1:0] rd_word,
	output logic bank_done,
	output logic [heap_pkg::freed_width-1:0] bank_freed
);

	logic [heap_pkg::payload_lsb-1:0] header [heap_pkg::slots_per_bank];
	heap_pkg::heap_payload_u payload [heap_pkg::slots_per_bank];
	logic [heap_pkg::slots_per_bank-1:0] root;
	logic [heap_pkg::state_width-1:0] state;
	logic [heap_pkg::pass_width-1:0] pass_cnt;

	logic [heap_pkg::colour_width-1:0] colour [heap_pkg::slots_per_bank];
	logic [heap_pkg::colour_width-1:0] next_colour [heap_pkg::slots_per_bank];
	logic [heap_pkg::slots_per_bank-1:0] is_head;
	logic [heap_pkg::slots_per_bank-1:0] dead;
	logic [heap_pkg::freed_width-1:0] freed_count;
	logic any_grey;
	logic owner_dead;

	function automatic logic [heap_pkg::payload_lsb-1:0] make_header(input logic head,
		input logic [heap_pkg::size_width-1:0] size, input logic refers);
		logic [heap_pkg::payload_lsb-1:0] h;
		h = '0;
		h[heap_pkg::used_bit] = 1'b1;
		h[heap_pkg::head_bit] = head;
		h[heap_pkg::size_lsb +: heap_pkg::size_width] = size;
		h[heap_pkg::colour_lsb +: heap_pkg::colour_width] = heap_pkg::colour_white;
		h[heap_pkg::refers_bit] = refers;
		return h;
	endfunction

	always_comb
	begin
		for (int s = 0; s < heap_pkg::slots_per_bank; s++)
		begin
			used_map[s] = header[s][heap_pkg::used_bit];
			is_head[s] = header[s][heap_pkg::used_bit] && header[s][heap_pkg::head_bit];
			colour[s] = header[s][heap_pkg::colour_lsb +: heap_pkg::colour_width];
		end
	end

	// one marking pass: grey heads turn black and grey their white link targets
	always_comb
	begin
		any_grey = 1'b0;
		for (int s = 0; s < heap_pkg::slots_per_bank; s++)
			next_colour[s] = colour[s];
		for (int s = 0; s < heap_pkg::slots_per_bank; s++)
		begin
			if (is_head[s] && colour[s] == heap_pkg::colour_grey)
			begin
				any_grey = 1'b1;
				next_colour[s] = heap_pkg::colour_black;
				if (header[s][heap_pkg::refers_bit] &&
					is_head[payload[s].link.target_slot] &&
					colour[payload[s].link.target_slot] == heap_pkg::colour_white)
					next_colour[payload[s].link.target_slot] = heap_pkg::colour_grey;
			end
		end
	end

	// tail slots share the fate of the head in front of them
	always_comb
	begin
		owner_dead = 1'b0;
		freed_count = '0;
		for (int s = 0; s < heap_pkg::slots_per_bank; s++)
		begin
			if (is_head[s])
				owner_dead = (colour[s] == heap_pkg::colour_white);
			dead[s] = used_map[s] && owner_dead;
			freed_count = freed_count + dead[s];
		end
	end

	always_ff @(posedge gc)
	begin
		if (reset)
		begin
			for (int s = 0; s < heap_pkg::slots_per_bank; s++)
				header[s] <= '0;
			root <= '0;
			state <= heap_pkg::st_idle;
			pass_cnt <= '0;
			bank_done <= 1'b0;
			bank_freed <= '0;
		end
		else
		begin
			bank_done <= 1'b0;
			for (int s = 0; s < heap_pkg::slots_per_bank; s++)
			begin
				if (wr_en && s >= wr_slot && s < wr_slot + wr_size)
				begin
					header[s] <= make_header(s == wr_slot, wr_size, wr_refers && s == wr_slot);
					root[s] <= (s == wr_slot);    // every new block starts as a root
				end
				else if (unroot_en && s == unroot_slot)
					root[s] <= 1'b0;
			end
			case (state)
				heap_pkg::st_idle:
				begin
					if (gc_start)
					begin
						for (int s = 0; s < heap_pkg::slots_per_bank; s++)
							header[s][heap_pkg::colour_lsb +: heap_pkg::colour_width] <= heap_pkg::colour_white;
						state <= heap_pkg::st_grey;
					end
				end
				heap_pkg::st_grey:
				begin
					for (int s = 0; s < heap_pkg::slots_per_bank; s++)
					begin
						if (is_head[s] && root[s])
							header[s][heap_pkg::colour_lsb +: heap_pkg::colour_width] <= heap_pkg::colour_grey;
					end
					pass_cnt <= '0;
					state <= heap_pkg::st_mark;
				end
				heap_pkg::st_mark:
				begin
					for (int s = 0; s < heap_pkg::slots_per_bank; s++)
						header[s][heap_pkg::colour_lsb +: heap_pkg::colour_width] <= next_colour[s];
					pass_cnt <= pass_cnt + 1'b1;
					if (!any_grey || pass_cnt == heap_pkg::depth_of_graph - 1)
						state <= heap_pkg::st_sweep;    // graph settled or depth limit hit
				end
				default:
				begin
					for (int s = 0; s < heap_pkg::slots_per_bank; s++)
					begin
						if (dead[s])
							header[s] <= '0;
						else
							header[s][heap_pkg::colour_lsb +: heap_pkg::colour_width] <= heap_pkg::colour_white;
					end
					bank_done <= 1'b1;
					bank_freed <= freed_count;
					state <= heap_pkg::st_idle;
				end
			endcase
		end
	end

	// head gets the payload, tails are zero filled
	always_ff @(posedge gc)
	begin
		for (int s = 0; s < heap_pkg::slots_per_bank; s++)
		begin
			if (wr_en && s >= wr_slot && s < wr_slot + wr_size)
				payload[s] <= (s == wr_slot) ? wr_payload : '0;
		end
		rd_word <= {payload[rd_slot], header[rd_slot]};
	end

endmodule

//--- source/alloc_dispatcher.sv
`timescale 1ns/100ps

module alloc_dispatcher
(
	input  logic gc,
	input  logic reset,
	input  logic alloc_valid,
	input  logic alloc_refers,
	input  logic [heap_pkg::size_width-1:0] alloc_size,
	input  heap_pkg::heap_payload_u alloc_payload,
	input  logic unroot_valid,
	input  logic [heap_pkg::bank_index_width-1:0] unroot_bank,
	input  logic [heap_pkg::slot_index_width-1:0] unroot_slot,
	input  logic gc_request,
	input  logic [heap_pkg::num_banks-1:0][heap_pkg::slots_per_bank-1:0] used_map,
	input  logic gc_done,
	input  logic [heap_pkg::freed_width-1:0] freed_total,
	output logic alloc_done,
	output logic alloc_ok,
	output logic [heap_pkg::bank_index_width-1:0] alloc_bank,
	output logic [heap_pkg::slot_index_width-1:0] alloc_slot,
	output logic [heap_pkg::num_banks-1:0] bank_wr,
	output logic [heap_pkg::slot_index_width-1:0] wr_slot,
	output logic [heap_pkg::size_width-1:0] wr_size,
	output logic wr_refers,
	output heap_pkg::heap_payload_u wr_payload,
	output logic [heap_pkg::num_banks-1:0] bank_unroot,
	output logic [heap_pkg::slot_index_width-1:0] unroot_slot_out,
	output logic gc_start,
	output logic gc_busy
);

	logic fit_found;
	logic [heap_pkg::bank_index_width-1:0] fit_bank;
	logic [heap_pkg::slot_index_width-1:0] fit_slot;
	logic accept;
	logic busy_q;
	logic auto_fired;      // threshold already triggered a collection
	logic trigger;
	logic [heap_pkg::freed_width-1:0] live_count;
	logic [heap_pkg::freed_width-1:0] live_next;

	// true when size slots from first are free and stay inside the bank
	function automatic logic block_free(input logic [heap_pkg::slots_per_bank-1:0] map,
		input int first, input logic [heap_pkg::size_width-1:0] size);
		logic ok;
		ok = (size != 0) && (size <= heap_pkg::max_block);
		ok = ok && (first + size <= heap_pkg::slots_per_bank);
		for (int k = 0; k < heap_pkg::max_block; k++)
		begin
			if (k < size && first + k < heap_pkg::slots_per_bank)
				ok = ok && !map[first + k];
		end
		return ok;
	endfunction

	// first fit, lowest bank first and then lowest slot
	always_comb
	begin
		fit_found = 1'b0;
		fit_bank = '0;
		fit_slot = '0;
		for (int b = 0; b < heap_pkg::num_banks; b++)
		begin
			for (int s = 0; s < heap_pkg::slots_per_bank; s++)
			begin
				if (!fit_found && block_free(used_map[b], s, alloc_size))
				begin
					fit_found = 1'b1;
					fit_bank = b[heap_pkg::bank_index_width-1:0];
					fit_slot = s[heap_pkg::slot_index_width-1:0];
				end
			end
		end
	end

	assign accept = alloc_valid && !gc_busy && fit_found;
	assign gc_busy = busy_q && !gc_done;    // drops together with the gc_done pulse
	assign trigger = !gc_busy && (gc_request || (live_count >= heap_pkg::gc_threshold && !auto_fired));

	// the bank write lands on the same edge that registers alloc_done
	always_comb
	begin
		for (int b = 0; b < heap_pkg::num_banks; b++)
		begin
			bank_wr[b] = accept && (fit_bank == b);
			bank_unroot[b] = unroot_valid && (unroot_bank == b);
		end
	end

	assign wr_slot = fit_slot;
	assign wr_size = alloc_size;
	assign wr_refers = alloc_refers;
	assign wr_payload = alloc_payload;
	assign unroot_slot_out = unroot_slot;

	always_comb
	begin
		live_next = live_count;
		if (accept)
			live_next = live_next + alloc_size;
		if (gc_done)
			live_next = live_next - freed_total;    // merger reports the slots reclaimed
	end

	always_ff @(posedge gc)
	begin
		if (reset)
		begin
			alloc_done <= 1'b0;
			alloc_ok <= 1'b0;
			gc_start <= 1'b0;
			busy_q <= 1'b0;
			auto_fired <= 1'b0;
			live_count <= '0;
		end
		else
		begin
			alloc_done <= alloc_valid;
			alloc_ok <= accept;
			gc_start <= trigger;
			live_count <= live_next;
			if (trigger)
				busy_q <= 1'b1;
			else if (gc_done)
				busy_q <= 1'b0;
			if (live_count < heap_pkg::gc_threshold)
				auto_fired <= 1'b0;    // rearm once the heap has drained
			else if (trigger)
				auto_fired <= 1'b1;
		end
	end

	always_ff @(posedge gc)
	begin
		alloc_bank <= fit_bank;
		alloc_slot <= fit_slot;
	end

endmodule

//--- source/heap_pkg.sv
package heap_pkg;

	// heap geometry
	localparam int heap_width = 24;        // payload over an 8-bit header
	localparam int payload_width = 16;
	localparam int num_banks = 4;
	localparam int slots_per_bank = 8;
	localparam int bank_index_width = 2;
	localparam int slot_index_width = 3;
	localparam int max_block = 4;          // largest block in slots
	localparam int size_width = 3;

	// header bit positions, same layout as the original collector
	localparam int used_bit = 0;
	localparam int head_bit = 1;
	localparam int size_lsb = 2;           // bits 2 to 4
	localparam int colour_lsb = 5;         // bits 5 and 6
	localparam int refers_bit = 7;
	localparam int payload_lsb = 8;

	localparam int colour_width = 2;
	localparam logic [1:0] colour_white = 2'b00;
	localparam logic [1:0] colour_grey = 2'b01;
	localparam logic [1:0] colour_black = 2'b11;

	// collector limits
	localparam int depth_of_graph = 10;    // most marking passes per collection
	localparam int pass_width = 4;
	localparam int gc_threshold = 22;      // 70 percent of the 32 heap slots
	localparam int freed_width = 6;

	// bank sequencer states, whitening happens on the idle edge that sees gc_start
	localparam int state_width = 2;
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_grey = 2'd1;
	localparam logic [1:0] st_mark = 2'd2;
	localparam logic [1:0] st_sweep = 2'd3;

	// a head payload is a link when its refers bit is set and plain data otherwise
	typedef union packed
	{
		logic [payload_width-1:0] data_word;
		struct packed
		{
			logic [payload_width-slot_index_width-1:0] unused;
			logic [slot_index_width-1:0] target_slot;    // head slot in the same bank
		} link;
	} heap_payload_u;

endpackage
